/* Makefile */
# Verilator flow for the instruction bus

VERILATOR  ?= verilator
FILE_LIST  := project.f
TB_TOP     := instr_bus_tb
RTL_TOP    := instr_bus_top
OBJ_DIR    := obj_dir
COMMON     := --timing --timescale 1ns/1ps
LINT_FLAGS := --lint-only $(COMMON)
SIM_FLAGS  := --binary --assert -j 0 $(COMMON)
PASS_MSG   := Verification passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILE_LIST)

# Pass or fail decided by the printed result line
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* hw/instr_bus_arbiter.sv */
/* Round-robin arbiter over the core AR channels.
   Cores must keep arvalid and payload stable until their transfer. */

`timescale 1ns/1ps

module instr_bus_arbiter
   import instr_bus_pkg::*;
(
   input  logic                      clk_i,
   input  logic                      reset_i,

   input  logic [NB_CORES-1:0]       s_arvalid_i,
   input  addr_t [NB_CORES-1:0]      s_araddr_i,
   input  prot_t [NB_CORES-1:0]      s_arprot_i,
   output logic [NB_CORES-1:0]       s_arready_o,

   output logic                      req_valid_o,
   output addr_t                     req_addr_o,
   output prot_t                     req_prot_o,
   output core_id_t                  req_core_o,
   input  logic                      req_ready_i
);

   core_id_t ptr_q;
   core_id_t pick;
   core_id_t cand;
   core_id_t grant;
   core_id_t lock_core_q;
   logic     lock_q;
   logic     found;

   // First requester at or after the pointer
   always_comb
   begin
      pick  = ptr_q;
      found = 1'b0;
      cand  = ptr_q;
      for (int k = 0; k < NB_CORES; k++)
      begin
         cand = core_id_t'((int'(ptr_q) + k) % NB_CORES);
         if (!found && s_arvalid_i[cand])
         begin
            pick  = cand;
            found = 1'b1;
         end
      end
   end

   // A waiting request keeps its grant
   assign grant       = lock_q ? lock_core_q : pick;

   assign req_valid_o = lock_q ? s_arvalid_i[lock_core_q] : found;
   assign req_addr_o  = s_araddr_i[grant];
   assign req_prot_o  = s_arprot_i[grant];
   assign req_core_o  = grant;

   always_comb
   begin
      s_arready_o        = '0;
      s_arready_o[grant] = req_valid_o && req_ready_i;
   end

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         ptr_q       <= '0;
         lock_q      <= 1'b0;
         lock_core_q <= '0;
      end
      else
      begin
         lock_q <= req_valid_o && !req_ready_i;
         if (req_valid_o && !req_ready_i)
            lock_core_q <= grant;
         // Served core drops to lowest priority
         if (req_valid_o && req_ready_i)
            ptr_q <= core_id_t'((int'(grant) + 1) % NB_CORES);
      end
   end

   a_one_ready: assert property (@(posedge clk_i) disable iff (reset_i)
      $onehot0(s_arready_o) && ((s_arready_o & ~s_arvalid_i) == '0));

   a_grant_held: assert property (@(posedge clk_i) disable iff (reset_i)
      req_valid_o && !req_ready_i |=>
         req_valid_o && req_core_o == $past(req_core_o) && req_addr_o == $past(req_addr_o));

endmodule

/* hw/instr_bus_pkg.sv */
/* Constants and types shared by the instruction bus.
   OUTSTANDING_DEPTH must be a power of two. Region bounds are inclusive. */

package instr_bus_pkg;

   //**************************************************************************
   // Sizes
   //**************************************************************************

   localparam int NB_CORES          = 4;
   localparam int ADDR_W            = 32;
   localparam int DATA_W            = 32;

   // Fetches that may be in flight at once
   localparam int OUTSTANDING_DEPTH = 4;
   localparam int OUTSTANDING_PTR_W = $clog2(OUTSTANDING_DEPTH);

   //**************************************************************************
   // Types
   //**************************************************************************

   typedef logic [ADDR_W-1:0]           addr_t;
   typedef logic [DATA_W-1:0]           data_t;
   typedef logic [1:0]                  resp_t;
   typedef logic [2:0]                  prot_t;
   typedef logic [$clog2(NB_CORES)-1:0] core_id_t;

   // AXI response codes in use
   localparam resp_t RESP_OKAY   = 2'b00;
   localparam resp_t RESP_DECERR = 2'b11;

   //**************************************************************************
   // Region map
   //**************************************************************************

   // Boot ROM
   localparam addr_t REGION0_START = 32'h0000_0000;
   localparam addr_t REGION0_END   = 32'h0000_FFFF;

   // L2 instruction window
   localparam addr_t REGION1_START = 32'h1C00_0000;
   localparam addr_t REGION1_END   = 32'h1C00_FFFF;

endpackage

/* hw/instr_bus_top.sv */
/* Cluster instruction bus, NB_CORES AXI4-Lite read slaves onto one master.
   Read channels only. Fetches outside both regions get a local DECERR. */

`timescale 1ns/1ps

module instr_bus_top
   import instr_bus_pkg::*;
(
   input  logic                 clk_i,
   input  logic                 reset_i,

   // Core fetch ports
   input  logic [NB_CORES-1:0]  s_arvalid_i,
   input  addr_t [NB_CORES-1:0] s_araddr_i,
   input  prot_t [NB_CORES-1:0] s_arprot_i,
   output logic [NB_CORES-1:0]  s_arready_o,
   output logic [NB_CORES-1:0]  s_rvalid_o,
   output data_t [NB_CORES-1:0] s_rdata_o,
   output resp_t [NB_CORES-1:0] s_rresp_o,
   input  logic [NB_CORES-1:0]  s_rready_i,

   // Memory side
   output logic                 m_arvalid_o,
   output addr_t                m_araddr_o,
   output prot_t                m_arprot_o,
   input  logic                 m_arready_i,
   input  logic                 m_rvalid_i,
   input  data_t                m_rdata_i,
   input  resp_t                m_rresp_i,
   output logic                 m_rready_o
);

   logic     req_valid;
   addr_t    req_addr;
   prot_t    req_prot;
   core_id_t req_core;
   logic     req_ready;
   logic     slot_free;
   logic     push;
   logic     push_err;

   //**************************************************************************
   // Request path
   //**************************************************************************

   instr_bus_arbiter arbiter_i (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .s_arvalid_i (s_arvalid_i),
      .s_araddr_i  (s_araddr_i),
      .s_arprot_i  (s_arprot_i),
      .s_arready_o (s_arready_o),
      .req_valid_o (req_valid),
      .req_addr_o  (req_addr),
      .req_prot_o  (req_prot),
      .req_core_o  (req_core),
      .req_ready_i (req_ready)
   );

   instr_region_decoder decoder_i (
      .req_valid_i (req_valid),
      .req_addr_i  (req_addr),
      .req_prot_i  (req_prot),
      .req_ready_o (req_ready),
      .slot_free_i (slot_free),
      .m_arvalid_o (m_arvalid_o),
      .m_araddr_o  (m_araddr_o),
      .m_arprot_o  (m_arprot_o),
      .m_arready_i (m_arready_i),
      .push_o      (push),
      .push_err_o  (push_err)
   );

   // Response path
   instr_resp_router router_i (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .push_i      (push),
      .push_core_i (req_core),
      .push_err_i  (push_err),
      .slot_free_o (slot_free),
      .m_rvalid_i  (m_rvalid_i),
      .m_rdata_i   (m_rdata_i),
      .m_rresp_i   (m_rresp_i),
      .m_rready_o  (m_rready_o),
      .s_rvalid_o  (s_rvalid_o),
      .s_rdata_o   (s_rdata_o),
      .s_rresp_o   (s_rresp_o),
      .s_rready_i  (s_rready_i)
   );

endmodule

/* hw/instr_region_decoder.sv */
/* Address check against the two fixed instruction regions.
   Purely combinational. A miss is accepted locally and never forwarded. */

`timescale 1ns/1ps

module instr_region_decoder
   import instr_bus_pkg::*;
(
   // Arbitrated request
   input  logic  req_valid_i,
   input  addr_t req_addr_i,
   input  prot_t req_prot_i,
   output logic  req_ready_o,

   // Outstanding FIFO has room
   input  logic  slot_free_i,

   // Master AR channel
   output logic  m_arvalid_o,
   output addr_t m_araddr_o,
   output prot_t m_arprot_o,
   input  logic  m_arready_i,

   // FIFO push
   output logic  push_o,
   output logic  push_err_o
);

   logic hit;

   // Inclusive bounds check
   function automatic logic in_region(addr_t addr, addr_t lo, addr_t hi);
      logic res;
      res = (addr >= lo) && (addr <= hi);
      return res;
   endfunction

   //**************************************************************************
   // Region match
   //**************************************************************************

   assign hit = in_region(req_addr_i, REGION0_START, REGION0_END) ||
                in_region(req_addr_i, REGION1_START, REGION1_END);

   //**************************************************************************
   // Issue
   //**************************************************************************

   // Hits go out only when the response has a slot waiting
   assign m_arvalid_o = req_valid_i && hit && slot_free_i;
   assign m_araddr_o  = req_addr_i;
   assign m_arprot_o  = req_prot_i;

   // Misses need only the slot
   assign req_ready_o = slot_free_i && (hit ? m_arready_i : 1'b1);

   // Every acceptance records an entry
   assign push_o      = req_valid_i && req_ready_o;
   assign push_err_o  = push_o && !hit;

endmodule

/* hw/instr_resp_router.sv */
/* In-order outstanding FIFO and R channel steering to the cores.
   Responses from the master port must come back in issue order. */

`timescale 1ns/1ps

module instr_resp_router
   import instr_bus_pkg::*;
(
   input  logic                 clk_i,
   input  logic                 reset_i,

   // Entry push from the decoder
   input  logic                 push_i,
   input  core_id_t             push_core_i,
   input  logic                 push_err_i,
   output logic                 slot_free_o,

   // Master R channel
   input  logic                 m_rvalid_i,
   input  data_t                m_rdata_i,
   input  resp_t                m_rresp_i,
   output logic                 m_rready_o,

   // Core R channels
   output logic [NB_CORES-1:0]  s_rvalid_o,
   output data_t [NB_CORES-1:0] s_rdata_o,
   output resp_t [NB_CORES-1:0] s_rresp_o,
   input  logic [NB_CORES-1:0]  s_rready_i
);

   typedef logic [OUTSTANDING_PTR_W-1:0] ptr_t;
   typedef logic [OUTSTANDING_PTR_W:0]   cnt_t;

   core_id_t core_q [OUTSTANDING_DEPTH];
   logic     err_q  [OUTSTANDING_DEPTH];

   ptr_t     wr_ptr_q;
   ptr_t     rd_ptr_q;
   cnt_t     count_q;
   cnt_t     fwd_cnt_q;

   logic     empty;
   logic     head_err;
   core_id_t head_core;
   logic     head_valid;
   data_t    head_data;
   resp_t    head_resp;
   logic     pop;

   assign empty       = (count_q == '0);
   assign slot_free_o = (count_q < cnt_t'(OUTSTANDING_DEPTH));

   assign head_core   = core_q[rd_ptr_q];
   assign head_err    = err_q[rd_ptr_q];

   //**************************************************************************
   // Head steering
   //**************************************************************************

   // Error entries answer by themselves
   assign head_valid = !empty && (head_err || m_rvalid_i);
   assign head_data  = head_err ? '0 : m_rdata_i;
   assign head_resp  = head_err ? RESP_DECERR : m_rresp_i;

   assign m_rready_o = !empty && !head_err && s_rready_i[head_core];
   assign pop        = head_valid && s_rready_i[head_core];

   always_comb
   begin
      for (int i = 0; i < NB_CORES; i++)
      begin
         s_rvalid_o[i] = head_valid && (head_core == core_id_t'(i));
         s_rdata_o[i]  = head_data;
         s_rresp_o[i]  = head_resp;
      end
   end

   //**************************************************************************
   // FIFO storage and pointers
   //**************************************************************************

   always_ff @(posedge clk_i)
   begin
      if (push_i)
      begin
         core_q[wr_ptr_q] <= push_core_i;
         err_q[wr_ptr_q]  <= push_err_i;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         wr_ptr_q  <= '0;
         rd_ptr_q  <= '0;
         count_q   <= '0;
         fwd_cnt_q <= '0;
      end
      else
      begin
         if (push_i)
            wr_ptr_q <= wr_ptr_q + 1'b1;
         if (pop)
            rd_ptr_q <= rd_ptr_q + 1'b1;
         count_q   <= count_q + cnt_t'(push_i) - cnt_t'(pop);
         // Entries still owed a master response
         fwd_cnt_q <= fwd_cnt_q + cnt_t'(push_i && !push_err_i)
                                - cnt_t'(pop && !head_err);
      end
   end

   a_no_push_full: assert property (@(posedge clk_i) disable iff (reset_i)
      push_i |-> slot_free_o);

   a_no_stray_rvalid: assert property (@(posedge clk_i) disable iff (reset_i)
      m_rvalid_i |-> fwd_cnt_q != '0);

endmodule

/* project.f */
hw/instr_bus_pkg.sv
hw/instr_bus_arbiter.sv
hw/instr_region_decoder.sv
hw/instr_resp_router.sv
hw/instr_bus_top.sv
tests/instr_mem_model.sv
tests/instr_bus_tb.sv

/* tests/instr_bus_tb.sv */
/* Testbench for the instruction bus with a memory model on the master port.
   Addresses must be unique within one test group. */

`timescale 1ns/1ps

module instr_bus_tb
   import instr_bus_pkg::*;
();

   localparam int    CLK_PERIOD    = 8;
   localparam int    SAMPLE_DELAY  = 3;
   localparam int    RESET_CYCLES  = 3;
   localparam int    GROUP_TIMEOUT = 2000;
   localparam int    MAX_ROWS      = 48;
   localparam int    RAND_ROWS     = 24;
   localparam int    ORDER_GROUP   = 10;
   localparam int    RAND_GROUP    = 12;
   localparam data_t DATA_KEY      = 32'hA5A5_5A5A;
   localparam prot_t FETCH_PROT    = 3'b100;

   logic                 clk;
   logic                 reset;
   logic [NB_CORES-1:0]  s_arvalid;
   addr_t [NB_CORES-1:0] s_araddr;
   prot_t [NB_CORES-1:0] s_arprot;
   logic [NB_CORES-1:0]  s_arready;
   logic [NB_CORES-1:0]  s_rvalid;
   data_t [NB_CORES-1:0] s_rdata;
   resp_t [NB_CORES-1:0] s_rresp;
   logic [NB_CORES-1:0]  s_rready;
   logic                 m_arvalid;
   addr_t                m_araddr;
   prot_t                m_arprot;
   logic                 m_arready;
   logic                 m_rvalid;
   data_t                m_rdata;
   resp_t                m_rresp;
   logic                 m_rready;
   logic                 stall;

   // Stimulus table, one row per fetch
   string    row_name  [MAX_ROWS];
   int       row_group [MAX_ROWS];
   core_id_t row_core  [MAX_ROWS];
   addr_t    row_addr  [MAX_ROWS];
   resp_t    row_resp  [MAX_ROWS];
   int       n_rows;

   logic [31:0] lfsr_state;
   int          n_tests;
   int          n_failed;
   int          n_errors;
   bit          timed_out;

   instr_bus_top dut (
      .clk_i       (clk),
      .reset_i     (reset),
      .s_arvalid_i (s_arvalid),
      .s_araddr_i  (s_araddr),
      .s_arprot_i  (s_arprot),
      .s_arready_o (s_arready),
      .s_rvalid_o  (s_rvalid),
      .s_rdata_o   (s_rdata),
      .s_rresp_o   (s_rresp),
      .s_rready_i  (s_rready),
      .m_arvalid_o (m_arvalid),
      .m_araddr_o  (m_araddr),
      .m_arprot_o  (m_arprot),
      .m_arready_i (m_arready),
      .m_rvalid_i  (m_rvalid),
      .m_rdata_i   (m_rdata),
      .m_rresp_i   (m_rresp),
      .m_rready_o  (m_rready)
   );

   instr_mem_model mem (
      .clk_i     (clk),
      .reset_i   (reset),
      .stall_i   (stall),
      .arvalid_i (m_arvalid),
      .araddr_i  (m_araddr),
      .arprot_i  (m_arprot),
      .arready_o (m_arready),
      .rvalid_o  (m_rvalid),
      .rdata_o   (m_rdata),
      .rresp_o   (m_rresp),
      .rready_i  (m_rready)
   );

   initial
   begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   //**************************************************************************
   // Helpers
   //**************************************************************************

   // Galois LFSR, x^32 + x^22 + x^2 + x + 1
   function automatic logic next_random_bit();
      logic out;
      out        = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (out)
         lfsr_state = lfsr_state ^ 32'h8020_0003;
      return out;
   endfunction

   // Each core fetches with its own protection attribute
   function automatic prot_t fetch_prot_for(int c);
      return FETCH_PROT | prot_t'(c);
   endfunction

   function automatic void add_row(string name, int g, int c, addr_t addr, resp_t resp);
      row_name[n_rows]  = name;
      row_group[n_rows] = g;
      row_core[n_rows]  = core_id_t'(c);
      row_addr[n_rows]  = addr;
      row_resp[n_rows]  = resp;
      n_rows++;
   endfunction

   // Next row of a group for one core, or -1
   function automatic int next_row(int g, core_id_t c, int from);
      for (int r = from; r < n_rows; r++)
         if (row_group[r] == g && row_core[r] == c)
            return r;
      return -1;
   endfunction

   function automatic int find_row(int g, addr_t addr);
      for (int r = 0; r < n_rows; r++)
         if (row_group[r] == g && row_addr[r] == addr)
            return r;
      return -1;
   endfunction

   task automatic check_data(input string name, input data_t exp, input data_t act);
      if (exp !== act)
      begin
         $display("Mismatch %s: data expected %h, actual %h", name, exp, act);
         n_errors++;
      end
   endtask

   task automatic check_resp(input string name, input resp_t exp, input resp_t act);
      if (exp !== act)
      begin
         $display("Mismatch %s: resp expected %0d, actual %0d", name, exp, act);
         n_errors++;
      end
   endtask

   task automatic check_core(input string name, input core_id_t exp, input core_id_t act);
      if (exp !== act)
      begin
         $display("Mismatch %s: core expected %0d, actual %0d", name, exp, act);
         n_errors++;
      end
   endtask

   task automatic check_prot(input string name, input prot_t exp, input prot_t act);
      if (exp !== act)
      begin
         $display("Mismatch %s: prot expected %0d, actual %0d", name, exp, act);
         n_errors++;
      end
   endtask

   task automatic apply_reset();
      @(negedge clk);
      reset = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
   endtask

   // Check one R transfer on core c against row r
   task automatic take_response(input int g, input int c, input int r, output int next);
      data_t exp_data;
      int    errs;
      if (r < 0)
      begin
         $display("Core %0d got a response with no fetch outstanding", c);
         n_errors++;
         next = -1;
      end
      else
      begin
         errs     = n_errors;
         exp_data = (row_resp[r] == RESP_OKAY) ? (row_addr[r] ^ DATA_KEY) : '0;
         check_data(row_name[r], exp_data, s_rdata[c]);
         check_resp(row_name[r], row_resp[r], s_rresp[c]);
         n_tests++;
         if (n_errors != errs)
         begin
            n_failed++;
            $display("Test %s: failed", row_name[r]);
         end
         else
            $display("Test %s: ok", row_name[r]);
         next = next_row(g, core_id_t'(c), r + 1);
      end
   endtask

   //**************************************************************************
   // Group runner, all rows of a group issued per core in table order
   //**************************************************************************

   task automatic run_group(input int g, input bit rand_mode, input bit check_order);
      int       issue_row [NB_CORES];
      int       resp_row  [NB_CORES];
      core_id_t ar_core   [$];
      int       cycles;
      int       r;
      int       nxt;
      bit       busy;
      for (int c = 0; c < NB_CORES; c++)
      begin
         issue_row[c] = next_row(g, core_id_t'(c), 0);
         resp_row[c]  = issue_row[c];
      end
      cycles = 0;
      busy   = 1'b1;
      while (busy && !timed_out)
      begin
         @(negedge clk);
         stall = rand_mode ? next_random_bit() : 1'b0;
         for (int c = 0; c < NB_CORES; c++)
         begin
            s_arvalid[c] = (issue_row[c] >= 0);
            if (issue_row[c] >= 0)
               s_araddr[c] = row_addr[issue_row[c]];
            s_rready[c] = rand_mode ? next_random_bit() : 1'b1;
         end
         // Sample just before the rising edge
         #(SAMPLE_DELAY);
         if (m_arvalid)
         begin
            r = find_row(g, m_araddr);
            if (r < 0 || row_resp[r] == RESP_DECERR)
            begin
               $display("Master AR raised for %h, which is no fetch inside a region", m_araddr);
               n_errors++;
            end
            else
            begin
               check_prot(row_name[r], fetch_prot_for(row_core[r]), m_arprot);
               if (m_arready)
                  ar_core.push_back(row_core[r]);
            end
         end
         for (int c = 0; c < NB_CORES; c++)
         begin
            if (s_arvalid[c] && s_arready[c])
               issue_row[c] = next_row(g, core_id_t'(c), issue_row[c] + 1);
            if (s_rvalid[c] && s_rready[c])
            begin
               take_response(g, c, resp_row[c], nxt);
               resp_row[c] = nxt;
            end
         end
         @(posedge clk);
         busy = 1'b0;
         for (int c = 0; c < NB_CORES; c++)
            if (issue_row[c] >= 0 || resp_row[c] >= 0)
               busy = 1'b1;
         cycles++;
         if (busy && cycles >= GROUP_TIMEOUT)
         begin
            $display("Timeout: group %0d still had open fetches after %0d cycles", g, cycles);
            timed_out = 1'b1;
         end
      end
      @(negedge clk);
      s_arvalid = '0;
      s_rready  = '1;
      stall     = 1'b0;
      if (check_order && !timed_out)
      begin
         if (ar_core.size() != NB_CORES)
         begin
            $display("Master port carried %0d fetches in group %0d instead of %0d",
                     ar_core.size(), g, NB_CORES);
            n_errors++;
         end
         for (int k = 0; k < ar_core.size() && k < NB_CORES; k++)
            check_core($sformatf("ar_order_%0d", k), core_id_t'(k), ar_core[k]);
      end
   endtask

   function automatic void fill_table();
      addr_t base;
      resp_t resp;
      n_rows = 0;
      // Name, group, core, address, expected response
      add_row("boot_core0",     0, 0, 32'h0000_0000, RESP_OKAY);
      add_row("boot_core1",     1, 1, 32'h0000_0124, RESP_OKAY);
      add_row("boot_core2",     2, 2, 32'h0000_8008, RESP_OKAY);
      add_row("boot_core3",     3, 3, 32'h0000_FFFC, RESP_OKAY);
      add_row("l2_core0",       4, 0, 32'h1C00_0000, RESP_OKAY);
      add_row("l2_core1",       5, 1, 32'h1C00_4410, RESP_OKAY);
      add_row("l2_core2",       6, 2, 32'h1C00_A0A0, RESP_OKAY);
      add_row("l2_core3",       7, 3, 32'h1C00_FFFC, RESP_OKAY);
      add_row("miss_gap",       8, 1, 32'h0001_0000, RESP_DECERR);
      add_row("miss_past_l2",   9, 3, 32'h1C01_0000, RESP_DECERR);
      add_row("all_core0",     10, 0, 32'h0000_1000, RESP_OKAY);
      add_row("all_core1",     10, 1, 32'h1C00_1004, RESP_OKAY);
      add_row("all_core2",     10, 2, 32'h0000_2008, RESP_OKAY);
      add_row("all_core3",     10, 3, 32'h1C00_300C, RESP_OKAY);
      add_row("seq_miss_a",    11, 2, 32'h8000_0000, RESP_DECERR);
      add_row("seq_hit",       11, 2, 32'h1C00_0840, RESP_OKAY);
      add_row("seq_miss_b",    11, 2, 32'hFFFF_FFFC, RESP_DECERR);
      // Mixed boot, L2 and miss fetches spread over all cores
      for (int i = 0; i < RAND_ROWS; i++)
      begin
         case (i % 3)
            0:       base = 32'h0000_4000;
            1:       base = 32'h1C00_8000;
            default: base = 32'h4000_0000;
         endcase
         resp = (i % 3 == 2) ? RESP_DECERR : RESP_OKAY;
         add_row($sformatf("rand_%0d", i), RAND_GROUP, i % NB_CORES, base + addr_t'(4 * i),
                 resp);
      end
   endfunction

   //**************************************************************************
   // Main sequence
   //**************************************************************************

   initial
   begin
      reset      = 1'b1;
      s_arvalid  = '0;
      s_araddr   = '0;
      for (int c = 0; c < NB_CORES; c++)
         s_arprot[c] = fetch_prot_for(c);
      s_rready   = '0;
      stall      = 1'b0;
      lfsr_state = 32'h1f54_81a7;
      n_tests    = 0;
      n_failed   = 0;
      n_errors   = 0;
      timed_out  = 1'b0;
      fill_table();
      apply_reset();
      for (int g = 0; g <= RAND_GROUP && !timed_out; g++)
      begin
         // Order test starts with the pointer back at core 0
         if (g == ORDER_GROUP)
            apply_reset();
         run_group(g, g == RAND_GROUP, g == ORDER_GROUP);
      end
      $display("Tests run %0d, failed %0d, errors %0d", n_tests, n_failed, n_errors);
      if (!timed_out && n_errors == 0)
         $display("Verification passed");
      else
         $display("Verification failed");
      $finish;
   end

endmodule

/* tests/instr_mem_model.sv */
/* AXI4-Lite read slave for simulation. Holds up to 4 reads and answers in order
   no earlier than 2 cycles after acceptance, data is the address XOR a fixed key. */

`timescale 1ns/1ps

module instr_mem_model
   import instr_bus_pkg::*;
(
   input  logic  clk_i,
   input  logic  reset_i,
   input  logic  stall_i,

   input  logic  arvalid_i,
   input  addr_t araddr_i,
   input  prot_t arprot_i,
   output logic  arready_o,

   output logic  rvalid_o,
   output data_t rdata_o,
   output resp_t rresp_o,
   input  logic  rready_i
);

   localparam int    DEPTH    = 4;
   localparam int    MIN_LAT  = 2;
   localparam data_t DATA_KEY = 32'hA5A5_5A5A;

   addr_t       addr_q  [DEPTH];
   int unsigned stamp_q [DEPTH];
   int unsigned cycle_q;
   logic [1:0]  wr_ptr_q;
   logic [1:0]  rd_ptr_q;
   logic [2:0]  count_q;
   logic        rvalid_q;
   logic        push;
   logic        pop;
   logic        head_due;

   // Stall gates acceptance and the start of a response
   assign arready_o = !stall_i && (count_q < 3'(DEPTH));
   assign push      = arvalid_i && arready_o;
   assign pop       = rvalid_q && rready_i;
   assign head_due  = (count_q != '0) && (cycle_q - stamp_q[rd_ptr_q] >= MIN_LAT);

   assign rvalid_o  = rvalid_q;
   assign rdata_o   = addr_q[rd_ptr_q] ^ DATA_KEY;
   assign rresp_o   = RESP_OKAY;

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
         rvalid_q <= 1'b0;
         cycle_q  <= '0;
      end
      else
      begin
         cycle_q <= cycle_q + 1;
         if (push)
         begin
            addr_q[wr_ptr_q]  <= araddr_i;
            stamp_q[wr_ptr_q] <= cycle_q;
            wr_ptr_q          <= wr_ptr_q + 1'b1;
         end
         // Once raised, rvalid holds until the transfer
         if (pop)
         begin
            rvalid_q <= 1'b0;
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         else if (!rvalid_q && head_due && !stall_i)
            rvalid_q <= 1'b1;
         count_q <= count_q + 3'(push) - 3'(pop);
      end
   end

endmodule
